//--- rv_mem_stage.f
verilog/rv_mem_pkg.sv
verilog/data_bus_if.sv
verilog/store_align.sv
verilog/load_extend.sv
verilog/data_memory.sv
verilog/mem_stage.sv
verilog/mem_subsystem.sv
verification/clk_rst_gen.sv
verification/tb_mem_subsystem.sv

//--- verification/clk_rst_gen.sv
`default_nettype none

module clk_rst_gen #(
    parameter int period_ns = 10,
    parameter int reset_cycles = 4
) (
    output logic me_clk,
    output logic me_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        me_clk = 1'b0;
        forever #(period_ns / 2) me_clk = ~me_clk;
    end

    // release lands just after an edge so no flop sees it together with the clock.
    initial begin
        me_rst = 1'b0;
        repeat (reset_cycles) @(posedge me_clk);
        #1;
        me_rst = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/mem_vectors.txt
# flush opcode funct3 rd alu_value rs2_data expect wb_rd_we wb_rd_data, all in hex.
# flush 1 is a flush cycle with no item; expect 0 marks an item whose writeback is dropped.
0 33 0 01 12345678 00000000 1 1 12345678
0 13 0 02 fffffff0 00000000 1 1 fffffff0
0 6f 0 03 00000104 00000000 1 1 00000104
0 67 0 04 00000208 00000000 1 1 00000208
0 37 0 05 abcde000 00000000 1 1 abcde000
0 17 0 06 80001000 00000000 1 1 80001000
0 03 2 07 00000040 00000000 1 1 00000000
0 23 2 00 00000010 cafebabe 1 0 00000000
0 03 2 08 00000010 00000000 1 1 cafebabe
0 33 0 09 00000055 00000000 1 1 00000055
0 23 0 00 00000014 000000a1 1 0 00000000
0 23 0 00 00000017 000000b2 1 0 00000000
0 23 1 00 00000015 0000c3d4 1 0 00000000
0 03 2 0a 00000014 00000000 1 1 b2c3d4a1
0 23 1 00 0000001a 1234f00d 1 0 00000000
0 23 1 00 00000018 00008001 1 0 00000000
0 23 0 00 00000019 0000007e 1 0 00000000
0 23 0 00 0000001a 000000ff 1 0 00000000
0 03 2 0b 00000018 00000000 1 1 f0ff7e01
0 03 0 0c 00000014 00000000 1 1 ffffffa1
0 03 4 0d 00000015 00000000 1 1 000000d4
0 03 0 0e 00000016 00000000 1 1 ffffffc3
0 03 4 0f 00000017 00000000 1 1 000000b2
0 03 1 10 00000014 00000000 1 1 ffffd4a1
0 03 5 11 00000015 00000000 1 1 0000c3d4
0 03 1 12 00000016 00000000 1 1 ffffb2c3
0 03 0 13 00000019 00000000 1 1 0000007e
0 03 1 14 00000019 00000000 1 1 ffffff7e
0 03 5 15 0000001a 00000000 1 1 0000f0ff
0 03 0 16 0000001b 00000000 1 1 fffffff0
0 03 2 17 00000018 00000000 0 0 00000000
1 00 0 00 00000000 00000000 0 0 00000000
0 23 2 00 00000020 5a5a5a5a 0 0 00000000
1 00 0 00 00000000 00000000 0 0 00000000
0 03 2 18 00000020 00000000 1 1 5a5a5a5a

//--- verification/tb_mem_subsystem.sv
`default_nettype none

module tb_mem_subsystem import rv_mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 10;
    localparam int max_vec = 64;
    localparam int wb_limit = 8;

    logic me_clk;
    logic me_rst;
    logic ce;
    logic [opcode_width-1:0] opcode;
    logic [funct_width-1:0] funct3;
    logic [reg_awidth-1:0] rd_addr;
    logic [xlen-1:0] alu_value;
    logic [xlen-1:0] rs2_data;
    logic flush;
    logic stall;
    logic flush_wb;
    logic wb_ce;
    logic wb_rd_we;
    logic [reg_awidth-1:0] wb_rd_addr;
    logic [xlen-1:0] wb_rd_data;

    logic v_flush [max_vec];
    logic [opcode_width-1:0] v_op [max_vec];
    logic [funct_width-1:0] v_f3 [max_vec];
    logic [reg_awidth-1:0] v_rd [max_vec];
    logic [xlen-1:0] v_alu [max_vec];
    logic [xlen-1:0] v_rs2 [max_vec];
    logic v_exp [max_vec];
    logic v_we [max_vec];
    logic [xlen-1:0] v_data [max_vec];

    int n_vec = 0;
    logic loaded = 1'b0;
    int cycle = 0;
    int exp_q[$];
    int acc_q[$];
    logic stall_seen = 1'b0;
    int value_errors = 0;
    int other_errors = 0;

    clk_rst_gen #(.period_ns(clk_period), .reset_cycles(4)) u_clk_rst (
        .me_clk (me_clk),
        .me_rst (me_rst)
    );

    mem_subsystem u_dut (
        .me_clk (me_clk),
        .me_rst (me_rst),
        .ce (ce),
        .opcode (opcode),
        .funct3 (funct3),
        .rd_addr (rd_addr),
        .alu_value (alu_value),
        .rs2_data (rs2_data),
        .flush (flush),
        .stall (stall),
        .flush_wb (flush_wb),
        .wb_ce (wb_ce),
        .wb_rd_we (wb_rd_we),
        .wb_rd_addr (wb_rd_addr),
        .wb_rd_data (wb_rd_data)
    );

    always @(posedge me_clk) begin
        cycle <= cycle + 1;
    end

    // ##########################################################
    // helpers
    // ##########################################################
    task automatic load_vectors();
        int fd;
        string line;
        fd = $fopen("verification/mem_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            other_errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#" && n_vec < max_vec) begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h %h %h", v_flush[n_vec],
                                v_op[n_vec], v_f3[n_vec], v_rd[n_vec], v_alu[n_vec],
                                v_rs2[n_vec], v_exp[n_vec], v_we[n_vec], v_data[n_vec]) == 9) begin
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name,
                     expected, actual);
            value_errors++;
        end
    endtask

    // the item stays on the inputs until a cycle ends with stall low.
    task automatic issue_item(input int i);
        logic taken;
        opcode = v_op[i];
        funct3 = v_f3[i];
        rd_addr = v_rd[i];
        alu_value = v_alu[i];
        rs2_data = v_rs2[i];
        ce = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge me_clk);
            if (stall) begin
                stall_seen = 1'b1;
            end else begin
                taken = 1'b1;
                if (v_exp[i]) begin
                    exp_q.push_back(i);
                    acc_q.push_back(cycle);
                end
            end
            @(posedge me_clk);
            #1;
        end
        ce = 1'b0;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge me_clk);
        #1;
        flush = 1'b0;
        @(negedge me_clk);
        check_value("flush_wb", 1'b1, flush_wb);
        @(posedge me_clk);
        #1;
    endtask

    task automatic check_writeback();
        int idx;
        int lat;
        assert (exp_q.size() > 0) else begin
            $display("writeback pulse at %0t with no item waiting for it", $time);
            other_errors++;
        end
        if (exp_q.size() > 0) begin
            idx = exp_q.pop_front();
            lat = (v_op[idx] == op_load || v_op[idx] == op_store) ? 1 + mem_wait_cycles : 1;
            check_value("wb_latency", lat, cycle - acc_q.pop_front());
            check_value("wb_rd_we", v_we[idx], wb_rd_we);
            if (v_we[idx]) begin
                check_value("wb_rd_addr", v_rd[idx], wb_rd_addr);
                check_value("wb_rd_data", v_data[idx], wb_rd_data);
            end
        end
    endtask

    // ##########################################################
    // writeback monitor
    // ##########################################################
    always @(negedge me_clk) begin
        if (me_rst === 1'b1) begin
            if (wb_ce) begin
                check_writeback();
            end else if (acc_q.size() > 0) begin
                assert (cycle - acc_q[0] <= wb_limit) else begin
                    $display("no writeback within %0d cycles for vector %0d", wb_limit,
                             exp_q[0]);
                    other_errors++;
                    void'(exp_q.pop_front());
                    void'(acc_q.pop_front());
                end
            end
        end
    end

    initial begin
        wait (loaded);
        #((n_vec * 20 + 100) * clk_period);
        $display("watchdog expired before the run finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        ce = 1'b0;
        opcode = '0;
        funct3 = '0;
        rd_addr = '0;
        alu_value = '0;
        rs2_data = '0;
        flush = 1'b0;
        load_vectors();
        assert (n_vec > 0) else begin
            $display("the vector file holds no usable lines");
            other_errors++;
        end
        @(posedge me_rst);
        @(posedge me_clk);
        #1;
        for (int i = 0; i < n_vec; i++) begin
            if (v_flush[i]) begin
                pulse_flush();
            end else begin
                issue_item(i);
            end
        end
        for (int k = 0; k < wb_limit + 2 && exp_q.size() > 0; k++) begin
            @(posedge me_clk);
        end
        repeat (2) @(posedge me_clk);
        assert (stall_seen) else begin
            $display("stall never went high while a memory item was pending");
            other_errors++;
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/data_bus_if.sv
`default_nettype none

interface data_bus_if import rv_mem_pkg::*; ();

    logic cyc;
    logic stb;
    logic we;
    logic [mem_awidth-1:0] addr;
    logic [3:0] byte_en;
    mem_word_t wdata;
    mem_word_t rdata;
    logic ack;

    modport stage (
        output cyc, stb, we, addr, byte_en, wdata,
        input rdata, ack
    );

    modport memory (
        input cyc, stb, we, addr, byte_en, wdata,
        output rdata, ack
    );

endinterface

`default_nettype wire

//--- verilog/data_memory.sv
`default_nettype none

module data_memory import rv_mem_pkg::*; (
    input wire me_clk,
    input wire me_rst,
    data_bus_if.memory bus
);

    mem_word_t mem [mem_words];
    logic [mem_awidth-1:0] addr_q;
    logic busy;
    logic [wait_cnt_width-1:0] wait_cnt;
    logic req;

    assign req = bus.cyc && bus.stb;
    assign bus.ack = busy && (wait_cnt == wait_cnt_width'(mem_wait_cycles - 1));
    assign bus.rdata = mem[addr_q];

    // ##########################################################
    // storage
    // ##########################################################
    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (req && bus.we) begin
            for (int l = 0; l < 4; l++) begin
                if (bus.byte_en[l]) begin
                    mem[bus.addr].lane[l] <= bus.wdata.lane[l];
                end
            end
        end
    end

    always_ff @(posedge me_clk) begin
        if (req) begin
            addr_q <= bus.addr;
        end
    end

    // ##########################################################
    // acknowledge delay
    // ##########################################################
    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            busy <= 1'b0;
            wait_cnt <= '0;
        end else if (req) begin
            busy <= 1'b1;
            wait_cnt <= '0;
        end else if (bus.ack) begin
            busy <= 1'b0;
        end else if (busy) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // a request may only land in the cycle that retires the previous one.
    a_single_outstanding: assert property (
        @(posedge me_clk) disable iff (!me_rst) req |-> (!busy || bus.ack)
    );

endmodule

`default_nettype wire

//--- verilog/load_extend.sv
`default_nettype none

module load_extend import rv_mem_pkg::*; (
    input wire [funct_width-1:0] funct3,
    input wire [1:0] offset,
    input wire mem_word_t rdata,
    output logic [xlen-1:0] value
);

    logic [1:0] hi_lane;
    logic [7:0] sel_byte;
    logic [15:0] sel_half;

    // offset 3 wraps for halfwords, which never reach here legally.
    assign hi_lane = offset + 2'd1;
    assign sel_byte = rdata.lane[offset];
    assign sel_half = {rdata.lane[hi_lane], rdata.lane[offset]};

    always_comb begin
        case (funct3)
            f_byte: value = {{24{sel_byte[7]}}, sel_byte};
            f_byte_u: value = {24'b0, sel_byte};
            f_half: value = {{16{sel_half[15]}}, sel_half};
            f_half_u: value = {16'b0, sel_half};
            f_word: value = rdata.word;
            default: value = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`default_nettype none

module mem_stage import rv_mem_pkg::*; (
    input wire me_clk,
    input wire me_rst,
    input wire ce,
    input wire [opcode_width-1:0] opcode,
    input wire [funct_width-1:0] funct3,
    input wire [reg_awidth-1:0] rd_addr,
    input wire [xlen-1:0] alu_value,
    input wire [xlen-1:0] rs2_data,
    input wire flush,
    output logic stall,
    output logic flush_wb,
    output logic wb_ce,
    output logic wb_rd_we,
    output logic [reg_awidth-1:0] wb_rd_addr,
    output logic [xlen-1:0] wb_rd_data,
    data_bus_if.stage bus
);

    logic is_load;
    logic is_store;
    logic is_mem;
    logic is_pass;
    logic accept;
    logic issue;
    logic [1:0] offset;
    logic pending;
    logic squash;
    logic pend_load;
    logic [funct_width-1:0] pend_funct3;
    logic [1:0] pend_offset;
    logic [reg_awidth-1:0] pend_rd;
    logic [xlen-1:0] load_value;

    // ##########################################################
    // decode and issue
    // ##########################################################
    assign is_load = (opcode == op_load);
    assign is_store = (opcode == op_store);
    assign is_mem = is_load || is_store;
    assign is_pass = (opcode == op_rtype) || (opcode == op_itype) || (opcode == op_jal) ||
                     (opcode == op_jalr) || (opcode == op_lui) || (opcode == op_auipc);
    assign offset = alu_value[1:0];

    // in the ack cycle the load result owns the next writeback slot, so only
    // another memory item may enter then.
    assign stall = pending && (!bus.ack || (ce && !is_mem));
    assign accept = ce && !stall && !flush;
    assign issue = accept && is_mem;

    assign bus.cyc = issue;
    assign bus.stb = issue;
    assign bus.we = issue && is_store;
    assign bus.addr = alu_value[mem_awidth+1:2];

    store_align u_store_align (
        .funct3 (funct3),
        .offset (offset),
        .rs2_data (rs2_data),
        .wdata (bus.wdata),
        .byte_en (bus.byte_en)
    );

    load_extend u_load_extend (
        .funct3 (pend_funct3),
        .offset (pend_offset),
        .rdata (bus.rdata),
        .value (load_value)
    );

    // ##########################################################
    // pending tracker and writeback
    // ##########################################################
    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            pending <= 1'b0;
            squash <= 1'b0;
            flush_wb <= 1'b0;
            wb_ce <= 1'b0;
            wb_rd_we <= 1'b0;
        end else begin
            flush_wb <= flush;
            wb_ce <= 1'b0;
            wb_rd_we <= 1'b0;
            if (bus.ack) begin
                pending <= 1'b0;
                squash <= 1'b0;
                if (!flush && !squash) begin
                    wb_ce <= 1'b1;
                    wb_rd_we <= pend_load;
                end
            end else if (flush && pending) begin
                // the bus still owes an ack, only its result is dropped.
                squash <= 1'b1;
            end
            if (accept) begin
                if (is_mem) begin
                    pending <= 1'b1;
                end else begin
                    wb_ce <= 1'b1;
                    wb_rd_we <= is_pass;
                end
            end
        end
    end

    always_ff @(posedge me_clk) begin
        if (issue) begin
            pend_load <= is_load;
            pend_funct3 <= funct3;
            pend_offset <= offset;
            pend_rd <= rd_addr;
        end
        if (bus.ack) begin
            wb_rd_addr <= pend_rd;
            wb_rd_data <= load_value;
        end
        if (accept && !is_mem) begin
            wb_rd_addr <= rd_addr;
            wb_rd_data <= alu_value;
        end
    end

    a_aligned_access: assert property (
        @(posedge me_clk) disable iff (!me_rst)
        issue |-> !(((funct3 == f_half) || (funct3 == f_half_u)) && (offset == 2'd3)) &&
                  !((funct3 == f_word) && (offset != 2'd0))
    );

    a_ack_expected: assert property (
        @(posedge me_clk) disable iff (!me_rst) bus.ack |-> pending
    );

endmodule

`default_nettype wire

//--- verilog/mem_subsystem.sv
`default_nettype none

module mem_subsystem import rv_mem_pkg::*; (
    input wire me_clk,
    input wire me_rst,
    input wire ce,
    input wire [opcode_width-1:0] opcode,
    input wire [funct_width-1:0] funct3,
    input wire [reg_awidth-1:0] rd_addr,
    input wire [xlen-1:0] alu_value,
    input wire [xlen-1:0] rs2_data,
    input wire flush,
    output logic stall,
    output logic flush_wb,
    output logic wb_ce,
    output logic wb_rd_we,
    output logic [reg_awidth-1:0] wb_rd_addr,
    output logic [xlen-1:0] wb_rd_data
);

    data_bus_if u_bus ();

    mem_stage u_stage (
        .me_clk (me_clk),
        .me_rst (me_rst),
        .ce (ce),
        .opcode (opcode),
        .funct3 (funct3),
        .rd_addr (rd_addr),
        .alu_value (alu_value),
        .rs2_data (rs2_data),
        .flush (flush),
        .stall (stall),
        .flush_wb (flush_wb),
        .wb_ce (wb_ce),
        .wb_rd_we (wb_rd_we),
        .wb_rd_addr (wb_rd_addr),
        .wb_rd_data (wb_rd_data),
        .bus (u_bus.stage)
    );

    data_memory u_mem (
        .me_clk (me_clk),
        .me_rst (me_rst),
        .bus (u_bus.memory)
    );

endmodule

`default_nettype wire

//--- verilog/rv_mem_pkg.sv
`default_nettype none

package rv_mem_pkg;

    // ##########################################################
    // widths and sizes
    // ##########################################################
    localparam int xlen = 32;
    localparam int mem_awidth = 5;
    localparam int mem_words = 2 ** mem_awidth;
    localparam int reg_awidth = 5;
    localparam int opcode_width = 7;
    localparam int funct_width = 3;

    // the memory answers this many cycles after the issue edge.
    localparam int mem_wait_cycles = 1;
    localparam int wait_cnt_width = $clog2(mem_wait_cycles + 1);

    // ##########################################################
    // RV32I encodings
    // ##########################################################
    localparam logic [opcode_width-1:0] op_load = 7'b0000011;
    localparam logic [opcode_width-1:0] op_store = 7'b0100011;
    localparam logic [opcode_width-1:0] op_rtype = 7'b0110011;
    localparam logic [opcode_width-1:0] op_itype = 7'b0010011;
    localparam logic [opcode_width-1:0] op_jal = 7'b1101111;
    localparam logic [opcode_width-1:0] op_jalr = 7'b1100111;
    localparam logic [opcode_width-1:0] op_lui = 7'b0110111;
    localparam logic [opcode_width-1:0] op_auipc = 7'b0010111;

    // loads and stores share the size field of funct3.
    localparam logic [funct_width-1:0] f_byte = 3'b000;
    localparam logic [funct_width-1:0] f_half = 3'b001;
    localparam logic [funct_width-1:0] f_word = 3'b010;
    localparam logic [funct_width-1:0] f_byte_u = 3'b100;
    localparam logic [funct_width-1:0] f_half_u = 3'b101;

    typedef union packed {
        logic [xlen-1:0] word;
        logic [xlen/8-1:0][7:0] lane;
    } mem_word_t;

endpackage

`default_nettype wire

//--- verilog/store_align.sv
`default_nettype none

module store_align import rv_mem_pkg::*; (
    input wire [funct_width-1:0] funct3,
    input wire [1:0] offset,
    input wire [xlen-1:0] rs2_data,
    output mem_word_t wdata,
    output logic [3:0] byte_en
);

    always_comb begin
        wdata.word = '0;
        byte_en = 4'b0000;
        case (funct3)
            f_byte: begin
                wdata.word = {4{rs2_data[7:0]}};
                byte_en = 4'b0001 << offset;
            end
            f_half: begin
                // shifting keeps the low byte in the lower enabled lane.
                wdata.word = {2{rs2_data[15:0]}} << {offset, 3'b000};
                case (offset)
                    2'd0: byte_en = 4'b0011;
                    2'd1: byte_en = 4'b0110;
                    2'd2: byte_en = 4'b1100;
                    default: byte_en = 4'b0000;
                endcase
            end
            f_word: begin
                wdata.word = rs2_data;
                byte_en = 4'b1111;
            end
            default: begin
                wdata.word = '0;
                byte_en = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire
